/* design/niuAlu.sv */
`default_nettype none
`timescale 1ns/1ps

module niuAlu (
    input  niuIsaPkg::aluFunc_e func,
    input  niuBusPkg::word_t    a,
    input  niuBusPkg::word_t    b,
    output niuBusPkg::word_t    result
);
    import niuIsaPkg::*;
    import niuBusPkg::*;

    always_comb begin
        case (func)
            SUB: result = a - b;
            ADD: result = a + b;
            NOT: result = ~a;  // b ignored
            AND: result = a & b;
            OR:  result = a | b;
            XOR: result = a ^ b;
            SUL: result = a << b;
            SUR: result = a >> b;
            SSR: result = $signed(a) >>> b;  // Sign fill

            // Unsigned compares for branches
            EQ:  result = word_t'(a == b);
            NEQ: result = word_t'(a != b);
            LT:  result = word_t'(a < b);
            LEQ: result = word_t'(a <= b);
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/niuBusPkg.sv */
`default_nettype none

package niuBusPkg;

    localparam int wordWidth = 32;

    typedef logic [wordWidth-1:0] word_t;

    localparam word_t resetPc = '0;

    // Request side of a memory port
    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  write;  // Low for reads
    } memReq_t;

    // Read data, one valid cycle per read
    typedef struct packed {
        logic  valid;
        word_t rdata;
    } memRsp_t;

endpackage

`default_nettype wire

/* design/niuCore.sv */
`default_nettype none
`timescale 1ns/1ps

module niuCore (
    input  logic               clk,
    input  logic               reset,
    output niuBusPkg::memReq_t imemReq,
    output logic               imemValid,
    input  logic               imemReady,
    input  niuBusPkg::memRsp_t imemRsp,
    output niuBusPkg::memReq_t dmemReq,
    output logic               dmemValid,
    input  logic               dmemReady,
    input  niuBusPkg::memRsp_t dmemRsp,
    output logic               halted
);
    import niuIsaPkg::*;
    import niuBusPkg::*;

    decodedInstr_t instr;
    logic          instrValid;
    logic          instrReady;
    word_t         pcNext;
    logic          done;
    logic          redirect;
    word_t         redirectPc;
    regIdx_t       rdAddrA;
    regIdx_t       rdAddrB;
    word_t         rdDataA;
    word_t         rdDataB;
    logic          wrEn;
    regIdx_t       wrAddr;
    word_t         wrData;

    niuFetch fetch (
        .clk, .reset, .imemReq, .imemValid, .imemReady, .imemRsp,
        .instr, .instrValid, .instrReady, .pcNext, .done, .redirect, .redirectPc
    );

    niuRegFile regFile (
        .clk, .reset, .rdAddrA, .rdAddrB, .rdDataA, .rdDataB, .wrEn, .wrAddr, .wrData
    );

    // Sequencer joins the decoded instruction with its operands
    niuExecute execute (
        .clk, .reset, .instr, .instrValid, .instrReady, .pcNext, .done, .redirect,
        .redirectPc, .rdAddrA, .rdAddrB, .rdDataA, .rdDataB, .wrEn, .wrAddr, .wrData,
        .dmemReq, .dmemValid, .dmemReady, .dmemRsp, .halted
    );

endmodule

`default_nettype wire

/* design/niuExecute.sv */
`default_nettype none
`timescale 1ns/1ps

module niuExecute (
    input  logic                     clk,
    input  logic                     reset,
    input  niuIsaPkg::decodedInstr_t instr,
    input  logic                     instrValid,
    output logic                     instrReady,
    input  niuBusPkg::word_t         pcNext,
    output logic                     done,
    output logic                     redirect,
    output niuBusPkg::word_t         redirectPc,
    output niuIsaPkg::regIdx_t       rdAddrA,
    output niuIsaPkg::regIdx_t       rdAddrB,
    input  niuBusPkg::word_t         rdDataA,
    input  niuBusPkg::word_t         rdDataB,
    output logic                     wrEn,
    output niuIsaPkg::regIdx_t       wrAddr,
    output niuBusPkg::word_t         wrData,
    output niuBusPkg::memReq_t       dmemReq,
    output logic                     dmemValid,
    input  logic                     dmemReady,
    input  niuBusPkg::memRsp_t       dmemRsp,
    output logic                     halted
);
    import niuIsaPkg::*;
    import niuBusPkg::*;

    typedef enum logic [2:0] {stIdle, stExecute, stMemReq, stMemWait, stError} execState_e;

    execState_e    state;
    decodedInstr_t cur;   // Instruction being executed
    memReq_t       dReq;
    aluFunc_e      aluFunc;
    word_t         operandB;
    word_t         aluResult;
    logic          isAluWrite;
    logic          isMem;
    logic          isBranch;
    logic          isJal;
    logic          isKnown;
    logic          taken;

    niuAlu alu (
        .func   (aluFunc),
        .a      (rdDataA),
        .b      (operandB),
        .result (aluResult)
    );

    // Opcode to ALU function and instruction class
    always_comb begin
        aluFunc    = ADD;
        isAluWrite = 1'b0;
        isMem      = 1'b0;
        isBranch   = 1'b0;
        isJal      = 1'b0;
        isKnown    = 1'b1;
        case (cur.op)
            ALUI: begin
                aluFunc    = cur.func;
                isAluWrite = 1'b1;
            end
            ADDI, ANDI, ORI, XORI, SULI, SURI: begin
                aluFunc    = aluFunc_e'(cur.op);  // Immediate codes match their functions
                isAluWrite = 1'b1;
            end
            LW, SW: isMem = 1'b1;  // Address is rx + imm
            BEQ: begin
                aluFunc  = EQ;
                isBranch = 1'b1;
            end
            BNE: begin
                aluFunc  = NEQ;
                isBranch = 1'b1;
            end
            BLT: begin
                aluFunc  = LT;
                isBranch = 1'b1;
            end
            BLE: begin
                aluFunc  = LEQ;
                isBranch = 1'b1;
            end
            JAL: isJal = 1'b1;
            default: isKnown = 1'b0;
        endcase
    end

    assign operandB = (cur.op == ALUI || isBranch) ? rdDataB : cur.imm;
    assign taken    = aluResult[0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= stIdle;
        end else begin
            case (state)
                stIdle: begin
                    if (instrValid) begin
                        state <= stExecute;
                    end
                end
                stExecute: begin
                    if (!isKnown) begin
                        state <= stError;
                    end else if (isMem) begin
                        state <= stMemReq;
                    end else begin
                        state <= stIdle;
                    end
                end
                stMemReq: begin
                    if (dmemReady) begin
                        state <= dReq.write ? stIdle : stMemWait;  // Stores get no reply
                    end
                end
                stMemWait: begin
                    if (dmemRsp.valid) begin
                        state <= stIdle;
                    end
                end
                default: state <= stError;  // Halt for good
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid && instrReady) begin
            cur <= instr;
        end
        if (state == stExecute && isMem) begin
            dReq <= '{addr: aluResult, wdata: rdDataB, write: (cur.op == SW)};
        end
    end

    assign instrReady = (state == stIdle);
    assign halted     = (state == stError);
    assign dmemReq    = dReq;
    assign dmemValid  = (state == stMemReq);
    assign rdAddrA    = cur.rx;
    assign rdAddrB    = cur.ry;

    // Writeback, ALUI targets rz and everything else ry
    assign wrEn   = (state == stExecute && (isAluWrite || isJal)) ||
                    (state == stMemWait && dmemRsp.valid);
    assign wrAddr = (cur.op == ALUI) ? cur.rz : cur.ry;
    assign wrData = (state == stMemWait) ? dmemRsp.rdata :
                    (isJal ? pcNext : aluResult);

    assign done = (state == stExecute && (isAluWrite || (isBranch && !taken))) ||
                  (state == stMemReq && dmemReady && dReq.write) ||
                  (state == stMemWait && dmemRsp.valid);
    assign redirect   = (state == stExecute) && (isJal || (isBranch && taken));
    assign redirectPc = isJal ? rdDataA : pcNext + cur.imm * word_t'(instrBytes);

endmodule

`default_nettype wire

/* design/niuFetch.sv */
`default_nettype none
`timescale 1ns/1ps

module niuFetch (
    input  logic                     clk,
    input  logic                     reset,
    output niuBusPkg::memReq_t       imemReq,
    output logic                     imemValid,
    input  logic                     imemReady,
    input  niuBusPkg::memRsp_t       imemRsp,
    output niuIsaPkg::decodedInstr_t instr,
    output logic                     instrValid,
    input  logic                     instrReady,
    output niuBusPkg::word_t         pcNext,
    input  logic                     done,
    input  logic                     redirect,
    input  niuBusPkg::word_t         redirectPc
);
    import niuIsaPkg::*;
    import niuBusPkg::*;

    typedef enum logic [2:0] {stStart, stRequest, stWait, stHold, stIdle} fetchState_e;

    fetchState_e state;
    word_t       pc;
    word_t       ir;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= stStart;
            pc    <= resetPc;
        end else begin
            case (state)
                stStart: state <= stRequest;
                stRequest: begin
                    if (imemReady) begin
                        pc    <= pc + word_t'(instrBytes);  // Step on acceptance
                        state <= stWait;
                    end
                end
                stWait: begin
                    if (imemRsp.valid) begin
                        state <= stHold;
                    end
                end
                stHold: begin
                    if (instrReady) begin
                        state <= stIdle;
                    end
                end
                stIdle: begin
                    // Execute owns the core until it reports back
                    if (redirect) begin
                        pc <= redirectPc;
                    end
                    if (redirect || done) begin
                        state <= stRequest;
                    end
                end
                default: state <= stStart;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stWait && imemRsp.valid) begin
            ir <= imemRsp.rdata;
        end
    end

    // Field split of the instruction register
    always_comb begin
        instr.op   = primaryOp_e'(ir[31:27]);
        instr.rx   = ir[26:22];
        instr.ry   = ir[21:17];
        instr.rz   = ir[16:12];
        instr.imm  = {{(wordWidth - immWidth){ir[immWidth-1]}}, ir[immWidth-1:0]};
        instr.func = aluFunc_e'(ir[4:0]);
    end

    assign imemReq    = '{addr: pc, wdata: '0, write: 1'b0};
    assign imemValid  = (state == stRequest);
    assign instrValid = (state == stHold);
    assign pcNext     = pc;  // Already incremented once the request is taken

endmodule

`default_nettype wire

/* design/niuIsaPkg.sv */
`default_nettype none

package niuIsaPkg;

    localparam int numRegs    = 32;
    localparam int instrBytes = 4;  // PC step per instruction
    localparam int immWidth   = 17;

    typedef logic [4:0] regIdx_t;

    // Primary opcode, instruction bits 31 to 27
    typedef enum logic [4:0] {
        ALUI = 5'b00000,
        ADDI = 5'b00001,
        ANDI = 5'b00101,
        ORI  = 5'b00110,
        XORI = 5'b00111,
        SULI = 5'b01000,
        SURI = 5'b01010,
        LW   = 5'b10000,
        SW   = 5'b10011,
        BEQ  = 5'b11000,
        BNE  = 5'b11001,
        BLT  = 5'b11010,
        BLE  = 5'b11011,
        JAL  = 5'b11111
    } primaryOp_e;

    // Secondary opcode of ALUI, compares are internal only
    typedef enum logic [4:0] {
        SUB = 5'b00000,
        ADD = 5'b00001,
        NOT = 5'b00100,
        AND = 5'b00101,
        OR  = 5'b00110,
        XOR = 5'b00111,
        SUL = 5'b01000,
        SUR = 5'b01010,
        SSR = 5'b01011,
        EQ  = 5'b10000,
        NEQ = 5'b10001,
        LT  = 5'b10010,
        LEQ = 5'b10011
    } aluFunc_e;

    typedef struct packed {
        primaryOp_e  op;
        aluFunc_e    func;
        regIdx_t     rx;
        regIdx_t     ry;
        regIdx_t     rz;
        logic [31:0] imm;  // Already sign-extended
    } decodedInstr_t;

endpackage

`default_nettype wire

/* design/niuRegFile.sv */
`default_nettype none
`timescale 1ns/1ps

module niuRegFile (
    input  logic               clk,
    input  logic               reset,
    input  niuIsaPkg::regIdx_t rdAddrA,
    input  niuIsaPkg::regIdx_t rdAddrB,
    output niuBusPkg::word_t   rdDataA,
    output niuBusPkg::word_t   rdDataB,
    input  logic               wrEn,
    input  niuIsaPkg::regIdx_t wrAddr,
    input  niuBusPkg::word_t   wrData
);
    import niuIsaPkg::*;
    import niuBusPkg::*;

    word_t regs [numRegs];  // r0 is an ordinary register

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Asynchronous reads
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the simulation with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module niuCoreTb -f vlog.f -o niuSim \
    && ./obj_dir/niuSim | tee /dev/stderr | grep -qF '*** PASSED ***' \
    && echo "Simulation passed" && exit 0
echo "Simulation failed"
exit 1

/* testbench/niuCoreTb.sv */
`default_nettype none
`timescale 1ns/1ps

module niuCoreTb;
    import niuIsaPkg::*;
    import niuBusPkg::*;

    localparam logic [2:0] kindReg    = 3'd0;
    localparam logic [2:0] kindImm    = 3'd1;
    localparam logic [2:0] kindMem    = 3'd2;
    localparam logic [2:0] kindBranch = 3'd3;
    localparam logic [2:0] kindJal    = 3'd4;
    localparam logic [2:0] kindBad    = 3'd5;

    localparam word_t resultAddr  = 32'h100;
    localparam word_t scratchAddr = 32'h180;
    localparam word_t jalAddr     = 32'h4;              // Slot of the jump in its template
    localparam word_t trapWord    = {5'b00010, 27'd0};  // Opcode outside the ISA
    localparam int    runLimit    = 150;                // Cycles per program

    typedef struct packed {
        logic [2:0] kind;
        logic [4:0] code;  // Primary opcode, or ALUI function for register rows
        word_t      a;
        word_t      b;
        word_t      expected;
    } testRow_t;

    logic    clk       = 1'b0;
    logic    reset     = 1'b1;
    memReq_t imemReq;
    logic    imemValid;
    logic    imemReady = 1'b0;
    memRsp_t imemRsp   = '0;
    memReq_t dmemReq;
    logic    dmemValid;
    logic    dmemReady = 1'b0;
    memRsp_t dmemRsp   = '0;
    logic    halted;

    word_t    prog [word_t];     // Byte address to instruction
    word_t    dataMem [word_t];
    testRow_t rows [$];
    string    rowNames [$];

    bit    iPending = 1'b0;
    bit    dPending = 1'b0;
    int    iDelay;
    int    dDelay;
    word_t iAddr;
    word_t dAddr;
    logic  resultSeen = 1'b0;
    word_t resultValue;
    word_t lfsr = 32'h911a;

    niuCore dut (
        .clk, .reset, .imemReq, .imemValid, .imemReady, .imemRsp,
        .dmemReq, .dmemValid, .dmemReady, .dmemRsp, .halted
    );

    always #50 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic nextRandomBit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic word_t randomBits(input int n);
        word_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], nextRandomBit()};
        end
        return v;
    endfunction

    function automatic word_t signExtend(input word_t v);
        return {{15{v[16]}}, v[16:0]};
    endfunction

    function automatic word_t applyFunc(input aluFunc_e f, input word_t x, input word_t y);
        case (f)
            SUB: return x - y;
            ADD: return x + y;
            NOT: return ~x;
            AND: return x & y;
            OR:  return x | y;
            XOR: return x ^ y;
            SUL: return (y > 32'd31) ? '0 : x << y[4:0];
            SUR: return (y > 32'd31) ? '0 : x >> y[4:0];
            SSR: return (y > 32'd31) ? {32{x[31]}} : word_t'($signed(x) >>> y[4:0]);
            default: return '0;
        endcase
    endfunction

    // Result that the store to 0x100 should carry
    function automatic word_t expectedResult(input logic [2:0] kind, input logic [4:0] code,
                                             input word_t a, input word_t b);
        word_t    x;
        word_t    y;
        aluFunc_e f;
        logic     taken;
        x = signExtend(a);  // Operands enter through ADDI
        y = signExtend(b);
        case (kind)
            kindReg: return applyFunc(aluFunc_e'(code), x, y);
            kindImm: begin
                case (primaryOp_e'(code))
                    ADDI:    f = ADD;
                    ANDI:    f = AND;
                    ORI:     f = OR;
                    XORI:    f = XOR;
                    SULI:    f = SUL;
                    default: f = SUR;
                endcase
                return applyFunc(f, x, y);
            end
            kindMem: return x;
            kindBranch: begin
                case (primaryOp_e'(code))  // Unsigned compares
                    BEQ:     taken = (x == y);
                    BNE:     taken = (x != y);
                    BLT:     taken = (x < y);
                    default: taken = (x <= y);
                endcase
                return taken ? 32'd2 : 32'd1;
            end
            kindJal: return jalAddr + word_t'(instrBytes);
            default: return '0;
        endcase
    endfunction

    function automatic word_t encodeImm(input primaryOp_e op, input regIdx_t rx,
                                        input regIdx_t ry, input word_t imm);
        return {op, rx, ry, imm[16:0]};
    endfunction

    function automatic word_t encodeReg(input aluFunc_e f, input regIdx_t rx,
                                        input regIdx_t ry, input regIdx_t rz);
        return {ALUI, rx, ry, rz, 7'd0, f};
    endfunction

    function automatic word_t fetchWord(input word_t addr);
        return prog.exists(addr) ? prog[addr] : trapWord;
    endfunction

    function automatic word_t readData(input word_t addr);
        return dataMem.exists(addr) ? dataMem[addr] : addr ^ 32'h5a5a_c3c3;
    endfunction

    task automatic addRow(input string name, input logic [2:0] kind, input logic [4:0] code,
                          input word_t a, input word_t b);
        testRow_t r;
        r = '{kind: kind, code: code, a: a, b: b, expected: expectedResult(kind, code, a, b)};
        rows.push_back(r);
        rowNames.push_back(name);
    endtask

    task automatic loadProgram(input testRow_t r);
        prog.delete();
        case (r.kind)
            kindReg: begin
                prog[32'h0] = encodeImm(ADDI, 5'd0, 5'd1, r.a);
                prog[32'h4] = encodeImm(ADDI, 5'd0, 5'd2, r.b);
                prog[32'h8] = encodeReg(aluFunc_e'(r.code), 5'd1, 5'd2, 5'd3);
                prog[32'hc] = encodeImm(SW, 5'd0, 5'd3, resultAddr);
            end
            kindImm: begin
                prog[32'h0] = encodeImm(ADDI, 5'd0, 5'd1, r.a);
                prog[32'h4] = encodeImm(primaryOp_e'(r.code), 5'd1, 5'd2, r.b);
                prog[32'h8] = encodeImm(SW, 5'd0, 5'd2, resultAddr);
            end
            kindMem: begin
                prog[32'h0] = encodeImm(ADDI, 5'd0, 5'd1, r.a);
                prog[32'h4] = encodeImm(SW, 5'd0, 5'd1, scratchAddr);
                prog[32'h8] = encodeImm(LW, 5'd0, 5'd4, scratchAddr);
                prog[32'hc] = encodeImm(SW, 5'd0, 5'd4, resultAddr);
            end
            kindBranch: begin
                prog[32'h0]  = encodeImm(ADDI, 5'd0, 5'd1, r.a);
                prog[32'h4]  = encodeImm(ADDI, 5'd0, 5'd2, r.b);
                prog[32'h8]  = encodeImm(ADDI, 5'd0, 5'd5, 32'd2);
                prog[32'hc]  = encodeImm(primaryOp_e'(r.code), 5'd1, 5'd2, 32'd1);
                prog[32'h10] = encodeImm(ADDI, 5'd0, 5'd5, 32'd1);  // Skipped when taken
                prog[32'h14] = encodeImm(SW, 5'd0, 5'd5, resultAddr);
            end
            kindJal: begin
                prog[32'h0]   = encodeImm(ADDI, 5'd0, 5'd6, r.a);
                prog[jalAddr] = encodeImm(JAL, 5'd6, 5'd7, 32'd0);
                prog[32'h8]   = encodeImm(SW, 5'd0, 5'd0, resultAddr);  // Fall-through stores 0
                prog[r.a]     = encodeImm(SW, 5'd0, 5'd7, resultAddr);
            end
            default: prog[32'h0] = trapWord;
        endcase
    endtask

    task automatic resetAndLoad(input testRow_t r);
        @(negedge clk);
        reset = 1'b1;
        @(negedge clk);
        loadProgram(r);
        repeat (15) @(negedge clk);
        reset = 1'b0;
    endtask

    // Both memory models share one process so the LFSR order is fixed
    always @(negedge clk) begin
        imemReady = 1'b0;
        imemRsp   = '0;
        dmemReady = 1'b0;
        dmemRsp   = '0;
        if (reset) begin
            iPending = 1'b0;
            dPending = 1'b0;
        end else begin
            if (iPending) begin
                if (iDelay == 0) begin
                    imemRsp  = '{valid: 1'b1, rdata: fetchWord(iAddr)};
                    iPending = 1'b0;
                end else begin
                    iDelay--;
                end
            end else if (imemValid && nextRandomBit()) begin
                imemReady = 1'b1;  // Taken on the next rising edge
                iPending  = 1'b1;
                iAddr     = imemReq.addr;
                iDelay    = randomBits(2);
            end
            if (dPending) begin
                if (dDelay == 0) begin
                    dmemRsp  = '{valid: 1'b1, rdata: readData(dAddr)};
                    dPending = 1'b0;
                end else begin
                    dDelay--;
                end
            end else if (dmemValid && nextRandomBit()) begin
                dmemReady = 1'b1;
                if (!dmemReq.write) begin
                    dPending = 1'b1;
                    dAddr    = dmemReq.addr;
                    dDelay   = randomBits(2);
                end
            end
        end
    end

    // Stores commit on the accepting edge
    always @(posedge clk) begin
        if (reset) begin
            dataMem.delete();
            resultSeen = 1'b0;
        end else if (dmemValid && dmemReady && dmemReq.write) begin
            dataMem[dmemReq.addr] = dmemReq.wdata;
            if (dmemReq.addr == resultAddr) begin
                resultSeen  = 1'b1;
                resultValue = dmemReq.wdata;
            end
        end
    end

    initial begin
        #1;
        #(rows.size() * 200 * 100);
        $display("Watchdog expired before all tests finished");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        testRow_t r;
        int       passCount;
        int       failCount;
        int       cycles;
        logic     failed;
        logic     sawFetch;
        passCount = 0;
        failCount = 0;

        addRow("sub",      kindReg, SUB, 32'd1000, 32'd37);
        addRow("subNeg",   kindReg, SUB, 32'd5, 32'd9);
        addRow("add",      kindReg, ADD, 32'h1fff0, 32'd100);
        addRow("not",      kindReg, NOT, 32'h1234, 32'd0);
        addRow("and",      kindReg, AND, 32'hf0f0, 32'h0ff0);
        addRow("or",       kindReg, OR, 32'hf000, 32'h000f);
        addRow("xor",      kindReg, XOR, 32'hffff, 32'h1234);
        addRow("sul",      kindReg, SUL, 32'h3, 32'd12);
        addRow("sur",      kindReg, SUR, 32'h1ff00, 32'd4);
        addRow("ssr",      kindReg, SSR, 32'h1ff00, 32'd4);
        addRow("addi",     kindImm, ADDI, 32'd5, 32'h1ffff);
        addRow("andi",     kindImm, ANDI, 32'h0ff0, 32'h00ff);
        addRow("ori",      kindImm, ORI, 32'h100, 32'h1);
        addRow("xori",     kindImm, XORI, 32'haaaa, 32'h1ffff);
        addRow("suli",     kindImm, SULI, 32'h7, 32'd28);
        addRow("suri",     kindImm, SURI, 32'h10000, 32'd16);
        addRow("loadStore", kindMem, LW, 32'h1abcd, 32'd0);
        addRow("beqTaken", kindBranch, BEQ, 32'd7, 32'd7);
        addRow("beqNot",   kindBranch, BEQ, 32'd7, 32'd8);
        addRow("bneTaken", kindBranch, BNE, 32'd7, 32'd8);
        addRow("bneNot",   kindBranch, BNE, 32'd3, 32'd3);
        addRow("bltTaken", kindBranch, BLT, 32'd2, 32'd5);
        addRow("bltNot",   kindBranch, BLT, 32'h1ffff, 32'd5);
        addRow("bleTaken", kindBranch, BLE, 32'd5, 32'd5);
        addRow("bleNot",   kindBranch, BLE, 32'd6, 32'd5);
        addRow("jal",      kindJal, JAL, 32'h10, 32'd0);
        addRow("badOp",    kindBad, 5'b00010, 32'd0, 32'd0);

        for (int i = 0; i < rows.size(); i++) begin
            r      = rows[i];
            failed = 1'b0;
            resetAndLoad(r);
            cycles = 0;
            while (!resultSeen && !halted && cycles < runLimit) begin
                @(negedge clk);
                cycles++;
            end
            if (r.kind == kindBad) begin
                sawFetch = 1'b0;
                for (int k = 0; k < 20; k++) begin  // Core must stay quiet after the halt
                    @(negedge clk);
                    sawFetch = sawFetch | imemValid;
                end
                assert (halted) else begin
                    $display("%s: core did not halt on an unknown opcode", rowNames[i]);
                    failed = 1'b1;
                end
                assert (!resultSeen) else begin
                    $display("%s: store to 0x100 after an unknown opcode", rowNames[i]);
                    failed = 1'b1;
                end
                assert (!sawFetch) else begin
                    $display("%s: instruction fetch continued after the halt", rowNames[i]);
                    failed = 1'b1;
                end
            end else begin
                assert (!halted) else begin
                    $display("%s: core halted unexpectedly", rowNames[i]);
                    failed = 1'b1;
                end
                assert (resultSeen) else begin
                    $display("%s: no store to 0x100 within %0d cycles", rowNames[i], runLimit);
                    failed = 1'b1;
                end
                if (resultSeen) begin
                    assert (resultValue == r.expected) else begin
                        $display("ERR %s expected %h actual %h",
                                 rowNames[i], r.expected, resultValue);
                        failed = 1'b1;
                    end
                end
            end
            $display("test %s: %s", rowNames[i], failed ? "fail" : "pass");
            if (failed) begin
                failCount++;
            end else begin
                passCount++;
            end
        end

        $display("%0d tests passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/niuCore_assert.sv */
`default_nettype none
`timescale 1ns/1ps

module niuCoreAssert (
    input logic               clk,
    input logic               reset,
    input niuBusPkg::memReq_t imemReq,
    input logic               imemValid,
    input logic               imemReady,
    input niuBusPkg::memReq_t dmemReq,
    input logic               dmemValid,
    input logic               dmemReady,
    input logic               halted
);

    // A stalled request keeps valid and contents
    imemHold: assert property (@(posedge clk) disable iff (reset)
        imemValid && !imemReady |=> imemValid && $stable(imemReq))
        else $error("imem request dropped or changed while stalled");

    dmemHold: assert property (@(posedge clk) disable iff (reset)
        dmemValid && !dmemReady |=> dmemValid && $stable(dmemReq))
        else $error("dmem request dropped or changed while stalled");

    resetQuiet: assert property (@(posedge clk) reset |-> !imemValid && !dmemValid)
        else $error("memory request valid during reset");

    haltStops: assert property (@(posedge clk) disable iff (reset) halted |-> !imemValid)
        else $error("instruction request after halt");

endmodule

bind niuCore niuCoreAssert coreChecks (
    .clk       (clk),
    .reset     (reset),
    .imemReq   (imemReq),
    .imemValid (imemValid),
    .imemReady (imemReady),
    .dmemReq   (dmemReq),
    .dmemValid (dmemValid),
    .dmemReady (dmemReady),
    .halted    (halted)
);

`default_nettype wire

/* vlog.f */
design/niuIsaPkg.sv
design/niuBusPkg.sv
design/niuAlu.sv
design/niuRegFile.sv
design/niuFetch.sv
design/niuExecute.sv
design/niuCore.sv
testbench/niuCore_assert.sv
testbench/niuCoreTb.sv
